// File: dv/mecobo_tb.sv
// mecobo command path testbench
`timescale 1ns/1ps
`default_nettype none

module mecobo_tb;

  import mecobo_bus_pkg::*;
  import mecobo_pin_pkg::*;

  localparam int max_ops = 64;
  localparam int reset_cycles = 4;
  localparam int square_reads = 4;
  // offset 3 of the last pin decodes to no register
  localparam logic [15:0] spare_reg = 16'h003f;

  logic        sys_clk;
  logic        global_clock_reset;
  ebi_addr_t   ebi_addr;
  ebi_word_t   ebi_wdata;
  logic        ebi_wr_n;
  logic        ebi_rd_n;
  logic        ebi_cs_n;
  ebi_word_t   ebi_rdata;
  logic        fpga_ready;
  logic [15:0] pins;

  // trace contents with one entry per operation line
  logic [63:0]  op_code [max_ops];
  logic [127:0] op_test [max_ops];
  logic [31:0]  op_a [max_ops];
  logic [31:0]  op_b [max_ops];
  int num_ops;
  int cycle_limit = 0;
  int cycle_count = 0;
  int mismatches = 0;
  int failures = 0;

  // waveform each pin holds once its commands are released
  logic [3:0] expected_wave [16];

  mecobo_core #(
    .NUM_PINS   (16),
    .FIFO_DEPTH (8)
  ) uut (.*);

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  // watchdog armed once the trace is loaded
  always @(posedge sys_clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: trace still running after %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // each host access starts and ends on a falling edge
  task automatic host_write(input ebi_addr_t addr, input ebi_word_t data);
    ebi_addr  = addr;
    ebi_wdata = data;
    ebi_cs_n  = 1'b0;
    ebi_wr_n  = 1'b0;
    @(negedge sys_clk);
    ebi_cs_n = 1'b1;
    ebi_wr_n = 1'b1;
  endtask

  // read data is registered on the rising edge inside the strobe
  task automatic host_read(input ebi_addr_t addr, output ebi_word_t data);
    ebi_addr = addr;
    ebi_cs_n = 1'b0;
    ebi_rd_n = 1'b0;
    @(negedge sys_clk);
    ebi_cs_n = 1'b1;
    ebi_rd_n = 1'b1;
    data = ebi_rdata;
  endtask

  // target holds register address high and data low
  task automatic send_command(input logic [31:0] release_time, input logic [31:0] target);
    int reg_addr;
    reg_addr = int'(target[31:16]);
    // waveform writes update the pin model
    if (reg_addr < 16 * pin_regs_per_pin &&
        reg_addr % pin_regs_per_pin == pin_reg_waveform) begin
      expected_wave[reg_addr / pin_regs_per_pin] = target[3:0];
    end
    host_write(cmd_word_base, release_time[15:0]);
    host_write(cmd_word_base + 19'd1, release_time[31:16]);
    host_write(cmd_word_base + 19'd2, target[31:16]);
    host_write(cmd_word_base + 19'd3, target[15:0]);
    // data high word commits
    host_write(cmd_commit_addr, 16'h0000);
  endtask

  // pins whose model holds them high at any time
  function automatic ebi_word_t steady_high();
    ebi_word_t levels;
    levels = '0;
    for (int p = 0; p < 16; p++) begin
      if (expected_wave[p] == wave_high) begin
        levels[p] = 1'b1;
      end
    end
    return levels;
  endfunction

  task automatic check_word(input logic [127:0] test, input ebi_word_t expected,
                            input ebi_word_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %0s expected %h actual %h", test, expected, actual);
      mismatches++;
    end
  endtask

  // reserved bits are not compared
  task automatic check_status(input logic [127:0] test, input ebi_status_t expected,
                              input ebi_status_t actual);
    if (actual.empty !== expected.empty || actual.full !== expected.full ||
        actual.overflow !== expected.overflow || actual.count !== expected.count) begin
      $display("MISMATCH %0s expected status %h actual status %h", test, expected, actual);
      mismatches++;
    end
  endtask

  task automatic check_ready(input logic [127:0] test, input logic expected,
                             input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %0s expected fpga_ready %b actual %b", test, expected, actual);
      mismatches++;
    end
  endtask

  task automatic run_op(input int i);
    ebi_word_t word;
    ebi_word_t first;
    ebi_word_t mask;
    logic      saw_high;
    logic      saw_low;
    int        n;
    case (op_code[i])
      64'("cmd"): send_command(op_a[i], op_b[i]);
      // far future commands into a spare register
      64'("fill"): for (n = 0; n < op_a[i]; n++) send_command(op_b[i], {spare_reg, 16'h0000});
      64'("wait"): repeat (op_a[i]) @(negedge sys_clk);
      64'("rd"): begin
        host_read(op_a[i][18:0], word);
        check_word(op_test[i], op_b[i][15:0], word);
        // pin outputs match their readback while levels hold
        if (op_a[i][18:0] == pin_level_addr) begin
          check_word(op_test[i], op_b[i][15:0], pins);
        end
      end
      64'("st"): begin
        host_read(status_addr, word);
        check_status(op_test[i], op_a[i][15:0], word);
        check_ready(op_test[i], op_b[i][0], fpga_ready);
      end
      64'("clk"): begin
        host_read(clock_lo_addr, first);
        repeat (op_a[i]) @(negedge sys_clk);
        host_read(clock_lo_addr, word);
        // the low half wraps cleanly for short waits
        if (ebi_word_t'(word - first) < op_a[i][15:0]) begin
          $display("MISMATCH %0s expected advance >= %0d actual %0d", op_test[i],
                   op_a[i], ebi_word_t'(word - first));
          mismatches++;
        end
      end
      64'("tog"): begin
        saw_high = 1'b0;
        saw_low  = 1'b0;
        mask = ebi_word_t'(1) << op_a[i][3:0];
        for (n = 0; n < square_reads; n++) begin
          if (n > 0) repeat (op_b[i]) @(negedge sys_clk);
          host_read(pin_level_addr, word);
          // every other pin holds its configured level
          check_word(op_test[i], steady_high() & ~mask, word & ~mask);
          if ((word & mask) != 0) saw_high = 1'b1;
          else saw_low = 1'b1;
        end
        if (!(saw_high && saw_low)) begin
          $display("%0s: pin %0d stayed at one level over %0d reads", op_test[i], op_a[i],
                   square_reads);
          failures++;
        end
      end
      default: begin
        $display("unknown operation in trace line %0d", i);
        failures++;
      end
    endcase
  endtask

  initial begin
    int          fd;
    int          code;
    int          ch;
    logic [63:0] op;
    logic [127:0] test;
    logic [31:0] a;
    logic [31:0] b;
    global_clock_reset = 1'b1;
    ebi_addr  = '0;
    ebi_wdata = '0;
    ebi_wr_n  = 1'b1;
    ebi_rd_n  = 1'b1;
    ebi_cs_n  = 1'b1;
    num_ops   = 0;
    for (int p = 0; p < 16; p++) begin
      expected_wave[p] = wave_low;
    end
    fd = $fopen("dv/mecobo_trace.txt", "r");
    if (fd == 0) begin
      $display("trace file dv/mecobo_trace.txt could not be opened");
      failures++;
    end else begin
      while (num_ops < max_ops) begin
        code = $fscanf(fd, " %s", op);
        if (code != 1) break;
        if (op == 64'("#")) begin
          // skip the rest of a comment line
          ch = 0;
          while (ch != 10 && ch != -1) ch = $fgetc(fd);
        end else begin
          code = $fscanf(fd, " %s %h %h", test, a, b);
          op_code[num_ops] = op;
          op_test[num_ops] = test;
          op_a[num_ops] = a;
          op_b[num_ops] = b;
          num_ops++;
        end
      end
      $fclose(fd);
    end
    if (num_ops == 0) begin
      $display("trace file holds no operations");
      failures++;
    end
    // budget of reset cycles plus 20 per operation plus every wait in the trace
    cycle_limit = reset_cycles;
    for (int i = 0; i < num_ops; i++) begin
      cycle_limit += 20;
      case (op_code[i])
        64'("wait"), 64'("clk"): cycle_limit += op_a[i];
        64'("tog"): cycle_limit += square_reads * op_b[i];
        64'("fill"): cycle_limit += 20 * op_a[i];
        default: ;
      endcase
    end
    repeat (reset_cycles) @(posedge sys_clk);
    @(negedge sys_clk);
    global_clock_reset = 1'b0;
    for (int i = 0; i < num_ops; i++) begin
      run_op(i);
    end
    $display("checks done: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/mecobo_trace.txt
# each line is op test a b with a and b in hex
# cmd time target_data  rd addr expect  st status ready  wait n  tog bit spacing  fill n time  clk n
st reset 0001 1
rd reset 20 0000
cmd pin3_high 28 000c0001
rd pin3_high 20 0000
wait pin3_high 30 0
rd pin3_high 20 0008
st pin3_high 0001 1
cmd in_order 12c 00040001
cmd in_order c8 00080001
wait in_order b4 0
rd in_order 20 0008
wait in_order 50 0
rd in_order 20 000e
cmd square 0 0015003f
cmd square 0 00140002
cmd square 0 00000001
wait square 8 0
tog square 5 64
fill full 9 ffff0000
wait full 2 0
st full 0806 0
clk clock 20 0
rd unmapped 30 0000

// File: logic/command_fifo.sv
// show-ahead command FIFO
`timescale 1ns/1ps
`default_nettype none

module command_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                        sys_clk,
  input  logic                        global_clock_reset,
  input  logic                        push,
  input  mecobo_bus_pkg::sched_cmd_t  push_cmd,
  input  logic                        pop,
  output logic                        head_valid,
  output mecobo_bus_pkg::sched_cmd_t  head_cmd,
  output mecobo_bus_pkg::ebi_status_t fifo_status,
  output logic                        not_full
);

  import mecobo_bus_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);

  sched_cmd_t     mem [FIFO_DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [AW:0]    count;
  logic           overflow;
  logic           full;
  logic           push_ok;
  logic           pop_ok;

  assign full    = (count == (AW+1)'(FIFO_DEPTH));
  assign push_ok = push & ~full;
  assign pop_ok  = pop & head_valid;

  // storage, pointer wraps at the power of two
  always_ff @(posedge sys_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push_ok) wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
      // simultaneous push and pop keeps the count
      count <= count + (AW+1)'(push_ok) - (AW+1)'(pop_ok);
      // dropped push, sticky until reset
      if (push && full) overflow <= 1'b1;
    end
  end

  // head is the oldest entry
  assign head_valid = (count != '0);
  assign head_cmd   = mem[rd_ptr];
  assign not_full   = ~full;

  always_comb begin
    fifo_status          = '0;
    fifo_status.empty    = ~head_valid;
    fifo_status.full     = full;
    fifo_status.overflow = overflow;
    fifo_status.count    = 8'(count);
  end

  // the scheduler only pops a valid head
  a_no_pop_when_empty: assert property (
    @(posedge sys_clk) disable iff (global_clock_reset)
    pop |-> head_valid
  );

endmodule

`default_nettype wire

// File: logic/command_scheduler.sv
// global clock and command release
`timescale 1ns/1ps
`default_nettype none

module command_scheduler (
  input  logic                       sys_clk,
  input  logic                       global_clock_reset,
  input  logic                       head_valid,
  input  mecobo_bus_pkg::sched_cmd_t head_cmd,
  output logic                       pop,
  output logic [31:0]                global_time,
  pin_bus_if.sched                   bus
);

  import mecobo_bus_pkg::*;

  logic time_reached;
  logic release_now;

  // free running timebase that counts every cycle
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      global_time <= '0;
    end else begin
      global_time <= global_time + 32'd1;
    end
  end

  // head waits until its timestamp is reached
  // later entries queue behind it in order
  assign time_reached = (global_time >= head_cmd.release_time);
  assign release_now  = head_valid & time_reached;

  // pop and register write on the same cycle
  // at most one command per cycle
  assign pop = release_now;

  assign bus.wr_en        = release_now;
  assign bus.addr         = head_cmd.target_addr;
  assign bus.data         = head_cmd.data;
  assign bus.current_time = global_time;

  // every pin write consumes exactly one FIFO entry
  a_wr_en_pops: assert property (
    @(posedge sys_clk) disable iff (global_clock_reset)
    bus.wr_en |-> pop && head_valid && (bus.current_time >= head_cmd.release_time)
  );

endmodule

`default_nettype wire

// File: logic/ebi_command_port.sv
// host bus command port
`timescale 1ns/1ps
`default_nettype none

module ebi_command_port #(
  parameter int NUM_PINS = 16
) (
  input  logic                        sys_clk,
  input  logic                        global_clock_reset,
  input  mecobo_bus_pkg::ebi_addr_t   ebi_addr,
  input  mecobo_bus_pkg::ebi_word_t   ebi_wdata,
  input  logic                        ebi_wr_n,
  input  logic                        ebi_rd_n,
  input  logic                        ebi_cs_n,
  output mecobo_bus_pkg::ebi_word_t   ebi_rdata,
  output logic                        push,
  output mecobo_bus_pkg::sched_cmd_t  push_cmd,
  input  mecobo_bus_pkg::ebi_status_t fifo_status,
  input  logic [31:0]                 global_time,
  input  logic [NUM_PINS-1:0]         pin_levels
);

  import mecobo_bus_pkg::*;

  // strobes are active low on the pins
  logic wr_access;
  logic rd_access;
  logic staging_hit;
  logic [2:0] word_idx;

  // five staging words, held until overwritten
  ebi_word_t staging [cmd_word_count];

  assign wr_access = ~ebi_cs_n & ~ebi_wr_n;
  assign rd_access = ~ebi_cs_n & ~ebi_rd_n;

  // word index within the staging block
  assign word_idx = 3'(ebi_addr - cmd_word_base);
  assign staging_hit = (ebi_addr >= cmd_word_base) &&
                       (ebi_addr < cmd_word_base + ebi_addr_t'(cmd_word_count));

  // capture staged words
  always_ff @(posedge sys_clk) begin
    if (wr_access && staging_hit) begin
      staging[word_idx] <= ebi_wdata;
    end
  end

  // commit pulse, one cycle after the last word
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      push <= 1'b0;
    end else begin
      push <= wr_access && (ebi_addr == cmd_commit_addr);
    end
  end

  // assembled command, stable while push is high
  always_comb begin
    push_cmd.release_time = {staging[1], staging[0]};
    push_cmd.target_addr  = staging[2];
    push_cmd.data         = {staging[4], staging[3]};
  end

  // registered readback
  // data holds until the next read strobe
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      ebi_rdata <= '0;
    end else if (rd_access) begin
      case (ebi_addr)
        status_addr:    ebi_rdata <= fifo_status;
        clock_lo_addr:  ebi_rdata <= global_time[15:0];
        clock_hi_addr:  ebi_rdata <= global_time[31:16];
        // unused upper bits read as zero
        pin_level_addr: ebi_rdata <= ebi_word_t'(pin_levels);
        default:        ebi_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/mecobo_bus_pkg.sv
// mecobo host bus definitions
`default_nettype none

package mecobo_bus_pkg;

  // one host data word, one host address
  typedef logic [15:0] ebi_word_t;
  typedef logic [18:0] ebi_addr_t;

  // command staging words
  // time lo, time hi, target addr, data lo, data hi
  localparam ebi_addr_t cmd_word_base = 19'h00;
  localparam int unsigned cmd_word_count = 5;
  // writing the last staging word commits the command
  localparam ebi_addr_t cmd_commit_addr = 19'h04;

  // readback registers
  localparam ebi_addr_t status_addr = 19'h10;
  localparam ebi_addr_t clock_lo_addr = 19'h11;
  localparam ebi_addr_t clock_hi_addr = 19'h12;
  // levels of pins 0..15
  localparam ebi_addr_t pin_level_addr = 19'h20;

  // one timestamped command, 80 bits
  typedef struct packed {
    logic [31:0] release_time;
    logic [15:0] target_addr;
    logic [31:0] data;
  } sched_cmd_t;

  // status word as the host sees it
  // bit 0 empty, bit 1 full, bit 2 sticky overflow
  typedef struct packed {
    logic [7:0] count;
    logic [4:0] reserved;
    logic       overflow;
    logic       full;
    logic       empty;
  } ebi_status_t;

endpackage

`default_nettype wire

// File: logic/mecobo_core.sv
// mecobo command path top
`timescale 1ns/1ps
`default_nettype none

module mecobo_core #(
  parameter int NUM_PINS   = 16,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                      sys_clk,
  input  logic                      global_clock_reset,
  input  mecobo_bus_pkg::ebi_addr_t ebi_addr,
  input  mecobo_bus_pkg::ebi_word_t ebi_wdata,
  input  logic                      ebi_wr_n,
  input  logic                      ebi_rd_n,
  input  logic                      ebi_cs_n,
  output mecobo_bus_pkg::ebi_word_t ebi_rdata,
  output logic                      fpga_ready,
  output logic [NUM_PINS-1:0]       pins
);

  import mecobo_bus_pkg::*;

  // host port to FIFO
  logic        push;
  sched_cmd_t  push_cmd;
  ebi_status_t fifo_status;

  // FIFO to scheduler
  logic        pop;
  logic        head_valid;
  sched_cmd_t  head_cmd;

  logic [31:0] global_time;

  // released commands fan out to every pin
  pin_bus_if bus ();

  ebi_command_port #(
    .NUM_PINS (NUM_PINS)
  ) u_ebi (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .ebi_addr           (ebi_addr),
    .ebi_wdata          (ebi_wdata),
    .ebi_wr_n           (ebi_wr_n),
    .ebi_rd_n           (ebi_rd_n),
    .ebi_cs_n           (ebi_cs_n),
    .ebi_rdata          (ebi_rdata),
    .push               (push),
    .push_cmd           (push_cmd),
    .fifo_status        (fifo_status),
    .global_time        (global_time),
    .pin_levels         (pins)
  );

  // ready to the host tracks FIFO space
  command_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .push               (push),
    .push_cmd           (push_cmd),
    .pop                (pop),
    .head_valid         (head_valid),
    .head_cmd           (head_cmd),
    .fifo_status        (fifo_status),
    .not_full           (fpga_ready)
  );

  command_scheduler u_sched (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .head_valid         (head_valid),
    .head_cmd           (head_cmd),
    .pop                (pop),
    .global_time        (global_time),
    .bus                (bus.sched)
  );

  // one controller per pin, window chosen by position
  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
    pin_controller #(
      .POSITION (i)
    ) u_pin (
      .sys_clk            (sys_clk),
      .global_clock_reset (global_clock_reset),
      .bus                (bus.pin),
      .pin                (pins[i])
    );
  end

endmodule

`default_nettype wire

// File: logic/mecobo_pin_pkg.sv
// pin controller register map
`default_nettype none

package mecobo_pin_pkg;

  // waveform codes held in the waveform register
  // unlisted codes drive the pin low
  typedef enum logic [3:0] {
    wave_low    = 4'd0,
    wave_high   = 4'd1,
    wave_square = 4'd2
  } waveform_t;

  // register offsets inside one pin's window
  localparam int unsigned pin_reg_waveform = 0;
  localparam int unsigned pin_reg_half_period = 1;

  // each pin owns a window of four addresses
  // pin n answers at n*4 .. n*4+3
  localparam int unsigned pin_regs_per_pin = 4;

  // half period register width, upper data bits ignored
  localparam int unsigned half_period_width = 28;

endpackage

`default_nettype wire

// File: logic/pin_bus_if.sv
// scheduler to pin command bus
`timescale 1ns/1ps
`default_nettype none

interface pin_bus_if;

  // one cycle pulse per released command
  logic        wr_en;
  // target register address, decoded by each pin
  logic [15:0] addr;
  logic [31:0] data;
  // global clock as seen by the pins
  logic [31:0] current_time;

  modport sched (
    output wr_en, addr, data, current_time
  );

  modport pin (
    input wr_en, addr, data, current_time
  );

endinterface

`default_nettype wire

// File: logic/pin_controller.sv
// per-pin waveform generator
`timescale 1ns/1ps
`default_nettype none

module pin_controller #(
  parameter int POSITION = 0
) (
  input  logic   sys_clk,
  input  logic   global_clock_reset,
  pin_bus_if.pin bus,
  output logic   pin
);

  import mecobo_pin_pkg::*;

  // this pin's address window
  localparam logic [15:0] reg_base = 16'(POSITION * pin_regs_per_pin);
  localparam logic [15:0] reg_end  = 16'((POSITION + 1) * pin_regs_per_pin);

  logic                         hit;
  logic [15:0]                  reg_offset;
  logic                         wr_waveform;
  logic                         wr_half_period;
  waveform_t                    waveform;
  logic [half_period_width-1:0] half_period;
  logic [half_period_width-1:0] tick;
  logic                         square_level;

  // decode against own window
  assign hit        = bus.wr_en && (bus.addr >= reg_base) && (bus.addr < reg_end);
  assign reg_offset = bus.addr - reg_base;
  assign wr_waveform    = hit && (reg_offset == 16'(pin_reg_waveform));
  assign wr_half_period = hit && (reg_offset == 16'(pin_reg_half_period));

  // configuration registers
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      waveform    <= wave_low;
      half_period <= '0;
    end else begin
      if (wr_waveform) waveform <= waveform_t'(bus.data[3:0]);
      if (wr_half_period) half_period <= bus.data[half_period_width-1:0];
    end
  end

  // square wave reload counter
  // toggles every half_period+1 cycles, starts low after any write
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      tick         <= '0;
      square_level <= 1'b0;
    end else if (wr_waveform || wr_half_period) begin
      tick         <= '0;
      square_level <= 1'b0;
    end else if (waveform == wave_square) begin
      if (tick >= half_period) begin
        tick         <= '0;
        square_level <= ~square_level;
      end else begin
        tick <= tick + 1'b1;
      end
    end else begin
      tick <= '0;
    end
  end

  // output register, one cycle behind the config
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      pin <= 1'b0;
    end else begin
      case (waveform)
        wave_high:   pin <= 1'b1;
        wave_square: pin <= square_level;
        // low and unknown codes
        default:     pin <= 1'b0;
      endcase
    end
  end

  // counter stays inside the stored period
  a_tick_in_range: assert property (
    @(posedge sys_clk) disable iff (global_clock_reset)
    tick <= half_period
  );

  // pins count half periods against a steady timebase
  a_timebase_steady: assert property (
    @(posedge sys_clk) disable iff (global_clock_reset)
    !global_clock_reset |=> bus.current_time == $past(bus.current_time) + 32'd1
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the mecobo testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module mecobo_tb -o mecobo_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/mecobo_sim > sim.log 2>&1; cat sim.log
grep -qx "RESULT: PASS" sim.log && echo "simulation passed" && exit 0 || exit 1

// File: sources.f
logic/mecobo_bus_pkg.sv
logic/mecobo_pin_pkg.sv
logic/pin_bus_if.sv
logic/ebi_command_port.sv
logic/command_fifo.sv
logic/command_scheduler.sv
logic/pin_controller.sv
logic/mecobo_core.sv
dv/mecobo_tb.sv
